//--- common/noc_consts.svh
// ##################################################
// Router sizing constants, shared by the RTL and the bench
// Port count is fixed at 5 by the port_e encoding
// ##################################################

`ifndef NOC_CONSTS_SVH
`define NOC_CONSTS_SVH

// Local, North, East, South, West
`define NOC_NUM_PORTS 5

// Bits per mesh coordinate
`define NOC_COORD_W 3

// Flit payload bits
`define NOC_PAYLOAD_W 32

// Input FIFO depth, at least 1
`define NOC_IN_DEPTH 2

`endif

//--- common/noc_pkg.sv
// ##################################################
// Flit and port types for the mesh router
// Field widths come from noc_consts.svh
// ##################################################

`include "noc_consts.svh"

package noc_pkg;

  // One mesh coordinate
  typedef logic [`NOC_COORD_W-1:0] coord_t;

  // Mesh position, x grows to the East and y to the North
  typedef struct packed {
    coord_t x;
    coord_t y;
  } xy_t;

  // Router port numbering, also the bit order of every port mask
  typedef enum logic [2:0] {
    PORT_LOCAL = 3'd0,
    PORT_NORTH = 3'd1,
    PORT_EAST  = 3'd2,
    PORT_SOUTH = 3'd3,
    PORT_WEST  = 3'd4
  } port_e;

  // One bit per router port
  typedef logic [`NOC_NUM_PORTS-1:0] port_mask_t;

  // Single flit, last marks the final flit of a packet
  typedef struct packed {
    xy_t                       dst;
    logic                      last;
    logic [`NOC_PAYLOAD_W-1:0] payload;
  } flit_t;

endpackage

//--- logic/noc_fifo.sv
// ##################################################
// Flit FIFO, output always comes from storage
// Full FIFO still accepts when popped in the same cycle
// ##################################################

`timescale 1ns/1ns

`include "noc_consts.svh"

module noc_fifo #(
  parameter int unsigned Depth = `NOC_IN_DEPTH
) (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  noc_pkg::flit_t data_i,
  input  logic           valid_i,
  output logic           ready_o,
  output noc_pkg::flit_t data_o,
  output logic           valid_o,
  input  logic           ready_i
);

  import noc_pkg::*;

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);
  localparam logic [PtrW-1:0] LastPtr = PtrW'(Depth - 1);
  localparam logic [CntW-1:0] FullCnt = CntW'(Depth);

  flit_t           mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            push;
  logic            pop;

  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];
  assign ready_o = (count_q != FullCnt) | ready_i;
  assign push    = valid_i & ready_o;
  assign pop     = valid_o & ready_i;

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Pointers wrap at Depth, which need not be a power of two
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == LastPtr) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == LastPtr) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

//--- logic/noc_route_stage.sv
// ##################################################
// Input buffering and XY route computation
// Assumes XY traffic: a masked route stalls its input
// ##################################################

`timescale 1ns/1ns

`include "noc_consts.svh"

module noc_route_stage (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  input  noc_pkg::xy_t                              xy_id_i,
  input  noc_pkg::port_mask_t                       in_valid_i,
  input  noc_pkg::flit_t     [`NOC_NUM_PORTS-1:0]   in_flit_i,
  output noc_pkg::port_mask_t                       in_ready_o,
  input  noc_pkg::port_mask_t                       pop_i,
  output noc_pkg::flit_t     [`NOC_NUM_PORTS-1:0]   head_flit_o,
  output noc_pkg::port_mask_t [`NOC_NUM_PORTS-1:0]  req_o
);

  import noc_pkg::*;

  port_mask_t                      head_valid;
  port_mask_t [`NOC_NUM_PORTS-1:0] route;

  // One input FIFO per port
  for (genvar p = 0; p < `NOC_NUM_PORTS; p++) begin : gen_in_fifo
    noc_fifo #(
      .Depth ( `NOC_IN_DEPTH )
    ) u_in_fifo (
      .clk_i   ( clk_i          ),
      .rst_n_i ( rst_n_i        ),
      .data_i  ( in_flit_i[p]   ),
      .valid_i ( in_valid_i[p]  ),
      .ready_o ( in_ready_o[p]  ),
      .data_o  ( head_flit_o[p] ),
      .valid_o ( head_valid[p]  ),
      .ready_i ( pop_i[p]       )
    );
  end

  // XY route, x is resolved first, then y, then local delivery
  always_comb begin
    for (int p = 0; p < `NOC_NUM_PORTS; p++) begin
      route[p] = '0;
      if (head_flit_o[p].dst.x > xy_id_i.x) begin
        route[p][PORT_EAST] = 1'b1;
      end else if (head_flit_o[p].dst.x < xy_id_i.x) begin
        route[p][PORT_WEST] = 1'b1;
      end else if (head_flit_o[p].dst.y > xy_id_i.y) begin
        route[p][PORT_NORTH] = 1'b1;
      end else if (head_flit_o[p].dst.y < xy_id_i.y) begin
        route[p][PORT_SOUTH] = 1'b1;
      end else begin
        route[p][PORT_LOCAL] = 1'b1;
      end
    end
  end

  // Transposed request matrix, indexed [output][input]
  for (genvar o = 0; o < `NOC_NUM_PORTS; o++) begin : gen_req_out
    for (genvar i = 0; i < `NOC_NUM_PORTS; i++) begin : gen_req_in
      // Loopback and Y to X turns are never wired
      if ((i == o) ||
          (((i == int'(PORT_NORTH)) || (i == int'(PORT_SOUTH))) &&
           ((o == int'(PORT_EAST)) || (o == int'(PORT_WEST))))) begin : gen_no_conn
        assign req_o[o][i] = 1'b0;
      end else begin : gen_conn
        assign req_o[o][i] = head_valid[i] & route[i][o];
      end
    end
  end

endmodule

//--- logic/noc_wormhole_arbiter.sv
// ##################################################
// Round-robin output arbiter with wormhole lock
// Lock is taken as soon as a flit is offered
// ##################################################

`timescale 1ns/1ns

`include "noc_consts.svh"

module noc_wormhole_arbiter (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  input  noc_pkg::port_mask_t                      req_i,
  input  noc_pkg::flit_t      [`NOC_NUM_PORTS-1:0] flits_i,
  output logic                                     valid_o,
  output noc_pkg::flit_t                           flit_o,
  input  logic                                     ready_i,
  output noc_pkg::port_mask_t                      gnt_o
);

  localparam int unsigned NumPorts = `NOC_NUM_PORTS;
  localparam int unsigned IdxW     = $clog2(NumPorts);

  logic            locked_q;
  logic [IdxW-1:0] lock_idx_q;
  logic [IdxW-1:0] rr_ptr_q;
  logic [IdxW-1:0] rr_idx;
  logic            rr_found;
  logic [IdxW-1:0] sel_idx;

  // Port index base + off, modulo the port count
  function automatic logic [IdxW-1:0] wrap_idx(input int unsigned base,
                                               input int unsigned off);
    int unsigned sum;
    sum = base + off;
    if (sum >= NumPorts) begin
      sum = sum - NumPorts;
    end
    return IdxW'(sum);
  endfunction

  // First requester at or after the round-robin pointer
  always_comb begin
    rr_found = 1'b0;
    rr_idx   = rr_ptr_q;
    for (int k = 0; k < NumPorts; k++) begin
      if (!rr_found && req_i[wrap_idx(rr_ptr_q, k)]) begin
        rr_found = 1'b1;
        rr_idx   = wrap_idx(rr_ptr_q, k);
      end
    end
  end

  // While locked only the owning input may send, even if its next flit is late
  assign sel_idx = locked_q ? lock_idx_q : rr_idx;
  assign valid_o = locked_q ? req_i[lock_idx_q] : rr_found;
  assign flit_o  = flits_i[sel_idx];

  always_comb begin
    gnt_o          = '0;
    gnt_o[sel_idx] = valid_o & ready_i;
  end

  // Locking on an offered flit keeps the output steady under back-pressure.
  // The lock and the pointer move only when the last flit transfers.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      locked_q   <= 1'b0;
      lock_idx_q <= '0;
      rr_ptr_q   <= '0;
    end else if (valid_o) begin
      if (ready_i && flit_o.last) begin
        locked_q <= 1'b0;
        rr_ptr_q <= wrap_idx(sel_idx, 1);
      end else begin
        locked_q   <= 1'b1;
        lock_idx_q <= sel_idx;
      end
    end
  end

endmodule

//--- logic/noc_grant_return.sv
// ##################################################
// Grant fold-back into FIFO pops and credit pulses
// Relies on one-hot routes, one grant per input
// ##################################################

`timescale 1ns/1ns

`include "noc_consts.svh"

module noc_grant_return (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  input  noc_pkg::port_mask_t [`NOC_NUM_PORTS-1:0]  gnt_i,
  output noc_pkg::port_mask_t                       pop_o,
  output noc_pkg::port_mask_t                       credit_o
);

  import noc_pkg::*;

  port_mask_t credit_q;

  // gnt_i is indexed [output][input], pop_o by input
  always_comb begin
    pop_o = '0;
    for (int i = 0; i < `NOC_NUM_PORTS; i++) begin
      for (int o = 0; o < `NOC_NUM_PORTS; o++) begin
        pop_o[i] = pop_o[i] | gnt_i[o][i];
      end
    end
  end

  // One credit pulse in the cycle after each pop
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      credit_q <= '0;
    end else begin
      credit_q <= pop_o;
    end
  end

  assign credit_o = credit_q;

endmodule

//--- logic/noc_router.sv
// ##################################################
// Five-port XY mesh router, single VC, wormhole
// Port order Local, North, East, South, West
// ##################################################

`timescale 1ns/1ns

`include "noc_consts.svh"

module noc_router (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  noc_pkg::xy_t                            xy_id_i,
  input  noc_pkg::port_mask_t                     in_valid_i,
  input  noc_pkg::flit_t     [`NOC_NUM_PORTS-1:0] in_flit_i,
  output noc_pkg::port_mask_t                     in_ready_o,
  output noc_pkg::port_mask_t                     in_credit_o,
  output noc_pkg::port_mask_t                     out_valid_o,
  output noc_pkg::flit_t     [`NOC_NUM_PORTS-1:0] out_flit_o,
  input  noc_pkg::port_mask_t                     out_ready_i
);

  import noc_pkg::*;

  // Both matrices are indexed [output][input]
  port_mask_t [`NOC_NUM_PORTS-1:0] req;
  port_mask_t [`NOC_NUM_PORTS-1:0] gnt;
  port_mask_t                      pop;
  flit_t      [`NOC_NUM_PORTS-1:0] head_flit;

  noc_route_stage u_route_stage (
    .clk_i       ( clk_i      ),
    .rst_n_i     ( rst_n_i    ),
    .xy_id_i     ( xy_id_i    ),
    .in_valid_i  ( in_valid_i ),
    .in_flit_i   ( in_flit_i  ),
    .in_ready_o  ( in_ready_o ),
    .pop_i       ( pop        ),
    .head_flit_o ( head_flit  ),
    .req_o       ( req        )
  );

  // One arbiter per output port
  for (genvar o = 0; o < `NOC_NUM_PORTS; o++) begin : gen_out_arb
    noc_wormhole_arbiter u_arbiter (
      .clk_i   ( clk_i          ),
      .rst_n_i ( rst_n_i        ),
      .req_i   ( req[o]         ),
      .flits_i ( head_flit      ),
      .valid_o ( out_valid_o[o] ),
      .flit_o  ( out_flit_o[o]  ),
      .ready_i ( out_ready_i[o] ),
      .gnt_o   ( gnt[o]         )
    );
  end

  noc_grant_return u_grant_return (
    .clk_i    ( clk_i       ),
    .rst_n_i  ( rst_n_i     ),
    .gnt_i    ( gnt         ),
    .pop_o    ( pop         ),
    .credit_o ( in_credit_o )
  );

endmodule

//--- bench/noc_router_assert.sv
// ##################################################
// Router protocol checks, bound into noc_router
// Reads the internal request and grant matrices
// ##################################################

`timescale 1ns/1ns

`include "noc_consts.svh"

module noc_router_assert (
  input logic                                     clk_i,
  input logic                                     rst_n_i,
  input noc_pkg::port_mask_t                      out_valid_i,
  input noc_pkg::flit_t      [`NOC_NUM_PORTS-1:0] out_flit_i,
  input noc_pkg::port_mask_t                      out_ready_i,
  input noc_pkg::port_mask_t [`NOC_NUM_PORTS-1:0] req_i,
  input noc_pkg::port_mask_t [`NOC_NUM_PORTS-1:0] gnt_i
);

  import noc_pkg::*;

  // Grants regrouped as [input][output]
  port_mask_t [`NOC_NUM_PORTS-1:0] gnt_by_in;
  // Failed assertions so far
  int unsigned                     fail_cnt = 0;

  always_comb begin
    for (int i = 0; i < `NOC_NUM_PORTS; i++) begin
      for (int o = 0; o < `NOC_NUM_PORTS; o++) begin
        gnt_by_in[i][o] = gnt_i[o][i];
      end
    end
  end

  for (genvar o = 0; o < `NOC_NUM_PORTS; o++) begin : gen_port
    // An offered flit stays put until the output takes it
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      out_valid_i[o] && !out_ready_i[o] |=> out_valid_i[o] && $stable(out_flit_i[o]))
      else begin
        fail_cnt = fail_cnt + 1;
        $error("output %0d changed or dropped a flit under back-pressure", o);
      end
    // An arbiter only grants an input that requests its output
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (gnt_i[o] & ~req_i[o]) == '0)
      else begin
        fail_cnt = fail_cnt + 1;
        $error("output %0d grants an input that does not request it", o);
      end
    assert property (@(posedge clk_i) disable iff (!rst_n_i) !gnt_i[o][o])
      else begin
        fail_cnt = fail_cnt + 1;
        $error("input %0d is granted its own output", o);
      end
    assert property (@(posedge clk_i) disable iff (!rst_n_i) $onehot0(gnt_by_in[o]))
      else begin
        fail_cnt = fail_cnt + 1;
        $error("input %0d is granted by more than one output", o);
      end
  end

  // North and South inputs never turn toward East or West
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(gnt_i[PORT_EAST][PORT_NORTH] || gnt_i[PORT_EAST][PORT_SOUTH] ||
      gnt_i[PORT_WEST][PORT_NORTH] || gnt_i[PORT_WEST][PORT_SOUTH]))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("a North or South input is granted East or West");
    end

endmodule

bind noc_router noc_router_assert u_router_assert (
  .clk_i       ( clk_i       ),
  .rst_n_i     ( rst_n_i     ),
  .out_valid_i ( out_valid_o ),
  .out_flit_i  ( out_flit_o  ),
  .out_ready_i ( out_ready_i ),
  .req_i       ( req         ),
  .gnt_i       ( gnt         )
);

//--- bench/noc_router_tb.sv
// ##################################################
// Router at (2,2), run from the project root
// Golden payload bits 31:28 tag the input port
// ##################################################

`timescale 1ns/1ns

`include "noc_consts.svh"

module noc_router_tb;

  import noc_pkg::*;

  localparam int          NumPorts      = `NOC_NUM_PORTS;
  localparam int          ClkPeriod     = 100;
  localparam int          ResetCycles   = 8;
  localparam int          CyclesPerFlit = 40;
  localparam logic [31:0] Seed          = 32'h7c58cd47;
  localparam xy_t         RouterXy      = '{x: coord_t'(2), y: coord_t'(2)};

  logic                 clk;
  logic                 rst_n;
  port_mask_t           in_valid;
  flit_t [NumPorts-1:0] in_flit;
  port_mask_t           in_ready;
  port_mask_t           in_credit;
  port_mask_t           out_valid;
  flit_t [NumPorts-1:0] out_flit;
  port_mask_t           out_ready;

  // Flits still to send per input, expected flits per [input][output] pair
  flit_t tx_q  [NumPorts][$];
  flit_t exp_q [NumPorts*NumPorts][$];
  int    sent_cnt   [NumPorts];
  int    credit_cnt [NumPorts];
  // Input whose packet is open on each output, -1 when none
  int    open_src   [NumPorts];
  int    num_flits;
  logic  loaded;
  logic  checks_on;

  noc_router DUT (
    .clk_i       ( clk       ),
    .rst_n_i     ( rst_n     ),
    .xy_id_i     ( RouterXy  ),
    .in_valid_i  ( in_valid  ),
    .in_flit_i   ( in_flit   ),
    .in_ready_o  ( in_ready  ),
    .in_credit_o ( in_credit ),
    .out_valid_o ( out_valid ),
    .out_flit_o  ( out_flit  ),
    .out_ready_i ( out_ready )
  );

  always #(ClkPeriod / 2) clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // X is resolved first, then Y, else the flit is delivered locally
  function automatic port_e xy_route(input xy_t dst);
    if (dst.x > RouterXy.x) return PORT_EAST;
    if (dst.x < RouterXy.x) return PORT_WEST;
    if (dst.y > RouterXy.y) return PORT_NORTH;
    if (dst.y < RouterXy.y) return PORT_SOUTH;
    return PORT_LOCAL;
  endfunction

  function automatic bit outputs_drained();
    for (int k = 0; k < NumPorts * NumPorts; k++) begin
      if (exp_q[k].size() != 0) return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "run stopped at %0t", $time);
  endtask

  task automatic check_flit(input string name, input flit_t want, input flit_t act);
    if (act !== want) begin
      fail_run($sformatf("mismatch %s expected %h actual %h", name, want, act));
    end
  endtask

  task automatic check_credits(input port_e port, input int want, input int act);
    if (act != want) begin
      fail_run($sformatf("mismatch credits_%s expected %0d actual %0d", port.name(), want, act));
    end
  endtask

  task automatic expect_mask(input string name, input port_mask_t want, input port_mask_t act);
    if (act !== want) begin
      fail_run($sformatf("mismatch %s expected %b actual %b", name, want, act));
    end
  endtask

  task automatic check_idle(input string phase);
    expect_mask({phase, "_out_valid"}, '0, out_valid);
    expect_mask({phase, "_in_credit"}, '0, in_credit);
    expect_mask({phase, "_in_ready"}, '1, in_ready);
  endtask

  task automatic load_golden();
    int                      fd;
    int                      n;
    int                      port;
    int                      dx;
    int                      dy;
    int                      last;
    int                      exp_out;
    logic [`NOC_PAYLOAD_W-1:0] payload;
    string                   line;
    flit_t                   f;
    fd = $fopen("bench/noc_router_golden.txt", "r");
    if (fd == 0) fail_run("cannot open bench/noc_router_golden.txt");
    while ($fgets(line, fd) != 0) begin
      if (line.getc(0) == "#" || line.getc(0) == "\n") begin
        continue;
      end
      n = $sscanf(line, "%d %d %d %h %d %d", port, dx, dy, payload, last, exp_out);
      f.dst.x   = coord_t'(dx);
      f.dst.y   = coord_t'(dy);
      f.last    = last[0];
      f.payload = payload;
      if (n != 6 || port < 0 || port >= NumPorts ||
          int'(payload[`NOC_PAYLOAD_W-1 -: 4]) != port) begin
        fail_run({"golden file line is malformed: ", line});
      end
      if (exp_out != int'(xy_route(f.dst))) begin
        fail_run({"golden output port disagrees with the XY route: ", line});
      end
      tx_q[port].push_back(f);
      exp_q[port * NumPorts + exp_out].push_back(f);
      sent_cnt[port]++;
      num_flits++;
    end
    $fclose(fd);
    if (num_flits == 0) fail_run("golden file holds no flits");
  endtask

  task automatic present_heads();
    for (int p = 0; p < NumPorts; p++) begin
      in_valid[p] = (tx_q[p].size() != 0);
      in_flit[p]  = in_valid[p] ? tx_q[p][0] : '0;
    end
  endtask

  // All inputs stream in parallel, so packets contend for outputs
  task automatic drive_inputs();
    port_mask_t taken;
    present_heads();
    while (in_valid != '0) begin
      @(negedge clk);
      taken = in_valid & in_ready;
      @(posedge clk);
      #1;
      for (int p = 0; p < NumPorts; p++) begin
        if (taken[p]) void'(tx_q[p].pop_front());
      end
      present_heads();
    end
  endtask

  task automatic check_output(input int o);
    flit_t want;
    int    src;
    src = int'(out_flit[o].payload[`NOC_PAYLOAD_W-1 -: 4]);
    if (src >= NumPorts) begin
      fail_run($sformatf("output %0d carried a flit from unknown input %0d", o, src));
    end
    if (open_src[o] >= 0 && open_src[o] != src) begin
      fail_run($sformatf("output %0d mixed input %0d into an open packet from input %0d",
                         o, src, open_src[o]));
    end
    if (exp_q[src * NumPorts + o].size() == 0) begin
      fail_run($sformatf("output %0d delivered an extra flit from input %0d", o, src));
    end
    want = exp_q[src * NumPorts + o].pop_front();
    check_flit($sformatf("route_in%0d_out%0d", src, o), want, out_flit[o]);
    open_src[o] = out_flit[o].last ? -1 : src;
  endtask

  // Sampled mid-cycle, where handshakes for the next edge are settled
  always @(negedge clk) begin
    if (checks_on) begin
      if (DUT.u_router_assert.fail_cnt != 0) begin
        fail_run("a bound protocol assertion failed");
      end
      for (int o = 0; o < NumPorts; o++) begin
        if (out_valid[o] && out_ready[o]) check_output(o);
      end
      for (int p = 0; p < NumPorts; p++) begin
        if (in_credit[p]) credit_cnt[p]++;
      end
    end
  end

  // Each output ready about three cycles in four
  initial begin : backpressure
    logic [31:0] state;
    state     = Seed;
    out_ready = '1;
    forever begin
      @(posedge clk);
      #1;
      state     = xorshift32(state);
      out_ready = state[4:0] | state[9:5];
    end
  end

  initial begin : watchdog
    wait (loaded);
    #((ResetCycles + CyclesPerFlit * num_flits) * ClkPeriod);
    fail_run("timeout before every golden flit was delivered");
  end

  initial begin : main
    clk       = 1'b0;
    rst_n     = 1'b0;
    in_valid  = '0;
    in_flit   = '0;
    checks_on = 1'b0;
    loaded    = 1'b0;
    num_flits = 0;
    for (int p = 0; p < NumPorts; p++) begin
      sent_cnt[p]   = 0;
      credit_cnt[p] = 0;
      open_src[p]   = -1;
    end
    load_golden();
    loaded = 1'b1;
    repeat (ResetCycles - 1) begin
      @(negedge clk);
      check_idle("in_reset");
    end
    @(posedge clk);
    #1;
    rst_n     = 1'b1;
    checks_on = 1'b1;
    @(negedge clk);
    check_idle("after_reset");
    @(posedge clk);
    #1;
    drive_inputs();
    while (!outputs_drained()) @(negedge clk);
    // Last credit pulse trails the last pop by one cycle
    repeat (3) @(negedge clk);
    for (int p = 0; p < NumPorts; p++) begin
      check_credits(port_e'(p), sent_cnt[p], credit_cnt[p]);
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule

//--- bench/noc_router_golden.txt
# in dst_x dst_y payload(hex, bits 31:28 = input port) last expected_out
# ports 0 Local, 1 North, 2 East, 3 South, 4 West; router at (2,2)
0 3 1 00000a01 0 2
0 3 1 00000a02 0 2
0 3 1 00000a03 1 2
0 2 3 00000b01 0 1
0 2 3 00000b02 1 1
0 1 4 00000c01 1 4
0 2 0 00000d01 1 3
1 2 2 10000a01 0 0
1 2 2 10000a02 1 0
1 2 0 10000b01 1 3
2 2 2 20000a01 0 0
2 2 2 20000a02 1 0
2 0 2 20000b01 1 4
2 2 4 20000c01 1 1
3 2 5 30000a01 0 1
3 2 5 30000a02 1 1
3 2 2 30000b01 1 0
4 4 2 40000a01 0 2
4 4 2 40000a02 0 2
4 4 2 40000a03 1 2
4 2 1 40000b01 1 3
4 2 2 40000c01 1 0

//--- noc_router.f
+incdir+common
common/noc_pkg.sv
logic/noc_fifo.sv
logic/noc_route_stage.sv
logic/noc_wormhole_arbiter.sv
logic/noc_grant_return.sv
logic/noc_router.sv
bench/noc_router_assert.sv
bench/noc_router_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the router testbench with Verilator from the project root
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --top-module noc_router_tb -f noc_router.f &&
  ./obj_dir/Vnoc_router_tb ||
  { echo "simulation did not pass" >&2; exit 1; }
